//--- radio_defs.svh
// Sizes and register map shared by RTL and testbench
// FIFO depth must stay a power of two for pointer wrap
`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

//--------------------------------------------------------------------------
// Receive buffer
//--------------------------------------------------------------------------
// Words held by the host-side FIFO
`define RADIO_FIFO_DEPTH 64
// Burst-ready level, count at or above this
`define RADIO_BURST 16

//--------------------------------------------------------------------------
// Identification and register map
//--------------------------------------------------------------------------
// Core version
`define RADIO_VERSION 8'd68
// Decimation, data bits 2..0, log2 of the ratio
`define RADIO_ADDR_DECIM 6'd0
// Transmit gain, data bits 1..0, right shift
`define RADIO_ADDR_GAIN 6'd1
// Clip status clear, data ignored
`define RADIO_ADDR_CLRSTAT 6'd2

`endif

//--- radio_pkg.sv
// Types for the AD9866 clock domain
// Samples and IQ words are two's complement
package radio_pkg;

  //------------------------------------------------------------------------
  // Data path widths
  //------------------------------------------------------------------------
  // One converter sample, ADC or DAC side
  typedef logic signed [11:0] adc_sample_t;

  // Half a sample on the AD9866 half-duplex bus
  typedef logic [5:0] nibble_t;

  // Decimated sum toward the host
  typedef logic signed [23:0] iq_word_t;

  // FIFO fill level, 0 to 64 inclusive
  typedef logic [6:0] fifo_count_t;

  //------------------------------------------------------------------------
  // Host command
  //------------------------------------------------------------------------
  // [40] run, [39] unused, [38:33] address, [32] ptt, [31:0] data
  typedef logic [47:0] cmd_word_t;

  // Register address field
  typedef logic [5:0] reg_addr_t;

  // Decimation ratio as a power of two, 0 to 4
  typedef logic [2:0] decim_log2_t;

  // Transmit attenuation as a right shift
  typedef logic [1:0] tx_shift_t;

  //------------------------------------------------------------------------
  // Receive nibble assembly
  //------------------------------------------------------------------------
  typedef enum logic {
    RX_WAIT_UPPER,
    RX_WAIT_LOWER
  } rx_phase_t;

endpackage

//--- radio_cfg_if.sv
// Control settings from the command registers to the data path
// All fields are levels except clr_status, a one-cycle pulse
interface radio_cfg_if;
  import radio_pkg::*;

  // Receive path enabled
  logic        run;
  // Transmit enabled
  logic        ptt;
  // log2 of the decimation ratio
  decim_log2_t decim_log2;
  // Transmit right shift
  tx_shift_t   tx_shift;
  // Clears sticky clip
  logic        clr_status;

  // Register block side
  modport regs (
    output run,
    output ptt,
    output decim_log2,
    output tx_shift,
    output clr_status
  );

  // Converter port and decimator side
  modport datapath (
    input run,
    input ptt,
    input decim_log2,
    input tx_shift,
    input clr_status
  );

endinterface

//--- cmd_regs.sv
// Command word decoder, one word per strobe
// Run and ptt follow every command, other fields only on address match
`include "radio_defs.svh"

module cmd_regs (
  input  logic                 clk_ad9866,
  input  logic                 reset,
  input  logic                 cmd_strobe,
  input  radio_pkg::cmd_word_t cmd_word,
  radio_cfg_if.regs            cfg
);
  import radio_pkg::*;

  // Largest ratio is 16
  localparam decim_log2_t DECIM_LOG2_MAX = 3'd4;

  reg_addr_t   cmd_addr;
  decim_log2_t decim_req;
  tx_shift_t   gain_req;

  //------------------------------------------------------------------------
  // Field extraction
  //------------------------------------------------------------------------
  // Bit 39 (response request) is not used here
  assign cmd_addr = cmd_word[38:33];

  // Out-of-range ratios saturate
  assign decim_req = (cmd_word[2:0] > DECIM_LOG2_MAX) ? DECIM_LOG2_MAX : cmd_word[2:0];

  assign gain_req = cmd_word[1:0];

  //------------------------------------------------------------------------
  // Registers
  //------------------------------------------------------------------------
  always_ff @(posedge clk_ad9866)
  begin
    if (reset)
    begin
      cfg.run        <= 1'b0;
      cfg.ptt        <= 1'b0;
      cfg.decim_log2 <= '0;
      cfg.tx_shift   <= '0;
      cfg.clr_status <= 1'b0;
    end
    else
    begin
      // Pulse by default
      cfg.clr_status <= 1'b0;
      if (cmd_strobe)
      begin
        // Carried in every word
        cfg.run <= cmd_word[40];
        cfg.ptt <= cmd_word[32];
        // Addressed registers
        case (cmd_addr)
          `RADIO_ADDR_DECIM:
            cfg.decim_log2 <= decim_req;
          `RADIO_ADDR_GAIN:
            cfg.tx_shift <= gain_req;
          `RADIO_ADDR_CLRSTAT:
            cfg.clr_status <= 1'b1;
          default:
            ;
        endcase
      end
    end
  end

endmodule

//--- ad9866_port.sv
// AD9866 half-duplex 6-bit bus, upper nibble first in both directions
// Transmit pins follow ptt in the same cycle; receive runs regardless of run
module ad9866_port (
  input  logic                   clk_ad9866,
  input  logic                   reset,
  input  logic [5:0]             rffe_ad9866_rx,
  input  logic                   rffe_ad9866_rxsync,
  output logic [5:0]             rffe_ad9866_tx,
  output logic                   rffe_ad9866_txsync,
  output logic                   rffe_ad9866_txquiet_n,
  input  radio_pkg::adc_sample_t tx_sample,
  output radio_pkg::adc_sample_t rx_sample,
  output logic                   rx_valid,
  radio_cfg_if.datapath          cfg
);
  import radio_pkg::*;

  rx_phase_t   rx_phase;
  nibble_t     rx_upper;
  logic        rx_done;

  adc_sample_t tx_scaled;
  nibble_t     tx_lower;
  logic        tx_lower_phase;

  //------------------------------------------------------------------------
  // Receive assembly
  //------------------------------------------------------------------------
  // Lower nibble cycle, no resync
  assign rx_done = (rx_phase == RX_WAIT_LOWER) && !rffe_ad9866_rxsync;

  always_ff @(posedge clk_ad9866)
  begin
    if (reset)
    begin
      rx_phase <= RX_WAIT_UPPER;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= rx_done;
      // rxsync always restarts
      if (rffe_ad9866_rxsync)
        rx_phase <= RX_WAIT_LOWER;
      else if (rx_phase == RX_WAIT_LOWER)
        rx_phase <= RX_WAIT_UPPER;
    end
  end

  // Sample registers
  always_ff @(posedge clk_ad9866)
  begin
    if (rffe_ad9866_rxsync)
      rx_upper <= rffe_ad9866_rx;
    if (rx_done)
      rx_sample <= {rx_upper, rffe_ad9866_rx};
  end

  //------------------------------------------------------------------------
  // Transmit split
  //------------------------------------------------------------------------
  // Gain as arithmetic attenuation
  assign tx_scaled = tx_sample >>> cfg.tx_shift;

  // Upper/lower toggle, parked on upper while quiet
  always_ff @(posedge clk_ad9866)
  begin
    if (reset)
      tx_lower_phase <= 1'b0;
    else if (!cfg.ptt)
      tx_lower_phase <= 1'b0;
    else
      tx_lower_phase <= !tx_lower_phase;
  end

  // Hold lower half of the sample sent in the upper cycle
  always_ff @(posedge clk_ad9866)
  begin
    if (cfg.ptt && !tx_lower_phase)
      tx_lower <= tx_scaled[5:0];
  end

  // Zero bus while not transmitting
  assign rffe_ad9866_tx = !cfg.ptt      ? '0 :
                          tx_lower_phase ? tx_lower : tx_scaled[11:6];

  // Marks the upper nibble
  assign rffe_ad9866_txsync = cfg.ptt && !tx_lower_phase;

  assign rffe_ad9866_txquiet_n = cfg.ptt;

endmodule

//--- rx_decimator.sv
// Boxcar decimation by 1, 2, 4, 8 or 16 with no gain correction
// Ratio changes are picked up at the next dump or while stopped
module rx_decimator (
  input  logic                   clk_ad9866,
  input  logic                   reset,
  input  radio_pkg::adc_sample_t rx_sample,
  input  logic                   rx_valid,
  radio_cfg_if.datapath          cfg,
  output radio_pkg::iq_word_t    iq_word,
  output logic                   iq_valid,
  output logic                   rxclip
);
  import radio_pkg::*;

  // Full-scale codes
  localparam adc_sample_t ADC_MAX = 12'sh7FF;
  localparam adc_sample_t ADC_MIN = 12'sh800;

  decim_log2_t decim_active;
  logic [3:0]  smp_cnt;
  logic [3:0]  last_idx;
  iq_word_t    acc;
  iq_word_t    sum;
  logic        dump;

  //------------------------------------------------------------------------
  // Accumulate and dump
  //------------------------------------------------------------------------
  // Terminal count for 2**decim_active samples
  assign last_idx = 4'((5'd1 << decim_active) - 5'd1);

  // Sign-extended running sum
  assign sum  = acc + {{12{rx_sample[11]}}, rx_sample};
  assign dump = cfg.run && rx_valid && (smp_cnt == last_idx);

  always_ff @(posedge clk_ad9866)
  begin
    if (reset)
    begin
      acc          <= '0;
      smp_cnt      <= '0;
      decim_active <= '0;
      iq_valid     <= 1'b0;
    end
    else
    begin
      iq_valid <= dump;
      if (!cfg.run || dump)
      begin
        // Fresh sum, ratio reloaded
        acc          <= '0;
        smp_cnt      <= '0;
        decim_active <= cfg.decim_log2;
      end
      else if (rx_valid)
      begin
        acc     <= sum;
        smp_cnt <= smp_cnt + 4'd1;
      end
    end
  end

  // Output word
  always_ff @(posedge clk_ad9866)
  begin
    if (dump)
      iq_word <= sum;
  end

  //------------------------------------------------------------------------
  // Sticky clip, clear wins
  //------------------------------------------------------------------------
  always_ff @(posedge clk_ad9866)
  begin
    if (reset)
      rxclip <= 1'b0;
    else if (cfg.clr_status)
      rxclip <= 1'b0;
    else if (rx_valid && (rx_sample == ADC_MAX || rx_sample == ADC_MIN))
      rxclip <= 1'b1;
  end

endmodule

//--- usiq_fifo.sv
// Single-clock first-word-fall-through FIFO of IQ words
// Writes when full are lost; reads when empty do nothing
`include "radio_defs.svh"

module usiq_fifo (
  input  logic                   clk_ad9866,
  input  logic                   reset,
  input  radio_pkg::iq_word_t    wr_data,
  input  logic                   wr_en,
  input  logic                   rd_en,
  output radio_pkg::iq_word_t    rd_data,
  output radio_pkg::fifo_count_t count,
  output logic                   burst_ready
);
  import radio_pkg::*;

  localparam int          ADDR_W = $clog2(`RADIO_FIFO_DEPTH);
  localparam fifo_count_t DEPTH  = fifo_count_t'(`RADIO_FIFO_DEPTH);
  localparam fifo_count_t BURST  = fifo_count_t'(`RADIO_BURST);

  iq_word_t          mem [`RADIO_FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic              wr_ok;
  logic              rd_ok;
  fifo_count_t       count_next;

  //------------------------------------------------------------------------
  // Accept rules
  //------------------------------------------------------------------------
  // Full drops, even with a pop in the same cycle
  assign wr_ok = wr_en && (count != DEPTH);
  assign rd_ok = rd_en && (count != '0);

  always_comb
  begin
    count_next = count;
    if (wr_ok && !rd_ok)
      count_next = count + 7'd1;
    else if (rd_ok && !wr_ok)
      count_next = count - 7'd1;
  end

  //------------------------------------------------------------------------
  // Storage
  //------------------------------------------------------------------------
  always_ff @(posedge clk_ad9866)
  begin
    if (wr_ok)
      mem[wr_ptr] <= wr_data;
  end

  // Oldest word always on the output
  assign rd_data = mem[rd_ptr];

  //------------------------------------------------------------------------
  // Pointers and level
  //------------------------------------------------------------------------
  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_ad9866)
  begin
    if (reset)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      burst_ready <= 1'b0;
    end
    else
    begin
      if (wr_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        rd_ptr <= rd_ptr + 1'b1;
      count       <= count_next;
      burst_ready <= (count_next >= BURST);
    end
  end

endmodule

//--- radio_core.sv
// AD9866 clock domain of the radio, one clock, no CDC
// Host side sees plain strobes and levels, no flow control
module radio_core (
  input  logic                   clk_ad9866,
  input  logic                   reset,

  // Host command
  input  logic                   cmd_strobe,
  input  radio_pkg::cmd_word_t   cmd_word,

  // AD9866 bus
  input  logic [5:0]             rffe_ad9866_rx,
  input  logic                   rffe_ad9866_rxsync,
  output logic [5:0]             rffe_ad9866_tx,
  output logic                   rffe_ad9866_txsync,
  output logic                   rffe_ad9866_txquiet_n,
  output logic                   rffe_ad9866_rst_n,

  // Host transmit sample, held level
  input  radio_pkg::adc_sample_t tx_sample,

  // Host receive stream
  input  logic                   rx_rd,
  output radio_pkg::iq_word_t    rx_data,
  output radio_pkg::fifo_count_t rx_count,
  output logic                   rx_samples,

  // Status
  output logic                   rxclip
);
  import radio_pkg::*;

  adc_sample_t rx_sample;
  logic        rx_valid;
  iq_word_t    iq_word;
  logic        iq_valid;

  //------------------------------------------------------------------------
  // Control
  //------------------------------------------------------------------------
  radio_cfg_if cfg ();

  cmd_regs cmd_regs_i (
    .clk_ad9866 (clk_ad9866),
    .reset      (reset),
    .cmd_strobe (cmd_strobe),
    .cmd_word   (cmd_word),
    .cfg        (cfg.regs)
  );

  // Converter held in reset with the core
  assign rffe_ad9866_rst_n = ~reset;

  //------------------------------------------------------------------------
  // Data path
  //------------------------------------------------------------------------
  ad9866_port ad9866_port_i (
    .clk_ad9866            (clk_ad9866),
    .reset                 (reset),
    .rffe_ad9866_rx        (rffe_ad9866_rx),
    .rffe_ad9866_rxsync    (rffe_ad9866_rxsync),
    .rffe_ad9866_tx        (rffe_ad9866_tx),
    .rffe_ad9866_txsync    (rffe_ad9866_txsync),
    .rffe_ad9866_txquiet_n (rffe_ad9866_txquiet_n),
    .tx_sample             (tx_sample),
    .rx_sample             (rx_sample),
    .rx_valid              (rx_valid),
    .cfg                   (cfg.datapath)
  );

  rx_decimator rx_decimator_i (
    .clk_ad9866 (clk_ad9866),
    .reset      (reset),
    .rx_sample  (rx_sample),
    .rx_valid   (rx_valid),
    .cfg        (cfg.datapath),
    .iq_word    (iq_word),
    .iq_valid   (iq_valid),
    .rxclip     (rxclip)
  );

  // Host-side buffer
  usiq_fifo usiq_fifo_i (
    .clk_ad9866  (clk_ad9866),
    .reset       (reset),
    .wr_data     (iq_word),
    .wr_en       (iq_valid),
    .rd_en       (rx_rd),
    .rd_data     (rx_data),
    .count       (rx_count),
    .burst_ready (rx_samples)
  );

endmodule

//--- tb_clock.sv
// Free-running testbench clock, 8 ns period, starts low
module tb_clock (
  output logic clk_ad9866
);
  timeunit 1ns;
  timeprecision 1ps;

  // Half period of the 125 MHz stand-in clock
  initial
  begin
    clk_ad9866 = 1'b0;
    forever
      #4 clk_ad9866 = ~clk_ad9866;
  end

endmodule

//--- radio_core_asserts.sv
// Pin-level rules of the core, bound into radio_core
// ptt is followed from the host command port, not read from inside the core
`include "radio_defs.svh"

module radio_core_asserts (
  input logic                   clk_ad9866,
  input logic                   reset,
  input logic                   cmd_strobe,
  input radio_pkg::cmd_word_t   cmd_word,
  input logic                   rffe_ad9866_txsync,
  input logic                   rffe_ad9866_txquiet_n,
  input radio_pkg::fifo_count_t rx_count
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  // Commanded ptt, bit 32 of every strobed word, one cycle late
  logic ptt;

  always_ff @(posedge clk_ad9866)
  begin
    if (reset)
      ptt <= 1'b0;
    else if (cmd_strobe)
      ptt <= cmd_word[32];
  end

  //------------------------------------------------------------------------
  // Transmit bus
  //------------------------------------------------------------------------
  // Upper and lower nibbles take turns
  txsync_alternates: assert property (@(posedge clk_ad9866) disable iff (reset)
    ptt && $past(ptt) |-> rffe_ad9866_txsync != $past(rffe_ad9866_txsync))
  else
  begin
    fail_count++;
    $error("txsync did not alternate while ptt was high");
  end

  // Quiet follows ptt
  quiet_without_ptt: assert property (@(posedge clk_ad9866) disable iff (reset)
    !ptt |-> !rffe_ad9866_txquiet_n)
  else
  begin
    fail_count++;
    $error("txquiet_n was high while ptt was low");
  end

  //------------------------------------------------------------------------
  // Receive buffer
  //------------------------------------------------------------------------
  count_in_range: assert property (@(posedge clk_ad9866) disable iff (reset)
    rx_count <= `RADIO_FIFO_DEPTH)
  else
  begin
    fail_count++;
    $error("rx_count went above the FIFO depth");
  end

endmodule

bind radio_core radio_core_asserts radio_core_asserts_i (
  .clk_ad9866            (clk_ad9866),
  .reset                 (reset),
  .cmd_strobe            (cmd_strobe),
  .cmd_word              (cmd_word),
  .rffe_ad9866_txsync    (rffe_ad9866_txsync),
  .rffe_ad9866_txquiet_n (rffe_ad9866_txquiet_n),
  .rx_count              (rx_count)
);

//--- radio_core_tb.sv
// Random test of radio_core against a transaction model of the core
// Inputs change on the falling edge; outputs are sampled there as well
`include "radio_defs.svh"

module radio_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import radio_pkg::*;

  localparam reg_addr_t ADDR_NONE  = 6'd3;
  localparam int        WAIT_LIMIT = 64;

  logic        clk_ad9866;
  logic        reset;
  logic        cmd_strobe;
  cmd_word_t   cmd_word;
  nibble_t     rffe_ad9866_rx;
  logic        rffe_ad9866_rxsync;
  nibble_t     rffe_ad9866_tx;
  logic        rffe_ad9866_txsync;
  logic        rffe_ad9866_txquiet_n;
  logic        rffe_ad9866_rst_n;
  adc_sample_t tx_sample;
  logic        rx_rd;
  iq_word_t    rx_data;
  fifo_count_t rx_count;
  logic        rx_samples;
  logic        rxclip;

  // Model state
  logic        m_run;
  logic        m_ptt;
  decim_log2_t m_decim;
  decim_log2_t m_decim_act;
  tx_shift_t   m_shift;
  iq_word_t    m_acc;
  int          m_cnt;
  logic        m_clip;
  iq_word_t    m_fifo[$];

  int mismatches = 0;
  int timeouts   = 0;

  tb_clock clock_i (
    .clk_ad9866 (clk_ad9866)
  );

  radio_core radio_core_i (
    .clk_ad9866            (clk_ad9866),
    .reset                 (reset),
    .cmd_strobe            (cmd_strobe),
    .cmd_word              (cmd_word),
    .rffe_ad9866_rx        (rffe_ad9866_rx),
    .rffe_ad9866_rxsync    (rffe_ad9866_rxsync),
    .rffe_ad9866_tx        (rffe_ad9866_tx),
    .rffe_ad9866_txsync    (rffe_ad9866_txsync),
    .rffe_ad9866_txquiet_n (rffe_ad9866_txquiet_n),
    .rffe_ad9866_rst_n     (rffe_ad9866_rst_n),
    .tx_sample             (tx_sample),
    .rx_rd                 (rx_rd),
    .rx_data               (rx_data),
    .rx_count              (rx_count),
    .rx_samples            (rx_samples),
    .rxclip                (rxclip)
  );

  //------------------------------------------------------------------------
  // Compare tasks
  //------------------------------------------------------------------------
  task automatic check_iq(string name, iq_word_t got, iq_word_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(string name, fifo_count_t got, fifo_count_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_nibble(string name, nibble_t got, nibble_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_timeout(string what);
    timeouts++;
    $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
  endtask

  //------------------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------------------
  // Register block, with the decimator's reload while stopped
  function automatic void apply_cmd(logic run, logic ptt, reg_addr_t addr,
                                    logic [31:0] data);
    if (run && !m_run)
      m_decim_act = m_decim;
    if (!run)
    begin
      m_acc = '0;
      m_cnt = 0;
    end
    m_run = run;
    m_ptt = ptt;
    if (addr == `RADIO_ADDR_DECIM)
      m_decim = (data[2:0] > 3'd4) ? 3'd4 : data[2:0];
    else if (addr == `RADIO_ADDR_GAIN)
      m_shift = data[1:0];
    else if (addr == `RADIO_ADDR_CLRSTAT)
      m_clip = 1'b0;
  endfunction

  // Clip flag, boxcar sum and FIFO with full drop
  function automatic void model_sample(adc_sample_t s);
    if (s == 12'sh7FF || s == 12'sh800)
      m_clip = 1'b1;
    if (m_run)
    begin
      m_acc = m_acc + iq_word_t'(s);
      m_cnt++;
      if (m_cnt == (1 << m_decim_act))
      begin
        if (m_fifo.size() < `RADIO_FIFO_DEPTH)
          m_fifo.push_back(m_acc);
        m_acc       = '0;
        m_cnt       = 0;
        m_decim_act = m_decim;
      end
    end
  endfunction

  //------------------------------------------------------------------------
  // Drivers
  //------------------------------------------------------------------------
  task automatic send_cmd(logic run, logic ptt, reg_addr_t addr, logic [31:0] data);
    @(negedge clk_ad9866);
    cmd_word        = '0;
    cmd_word[40]    = run;
    // Ignored bit, randomized on purpose
    cmd_word[39]    = 1'($urandom);
    cmd_word[38:33] = addr;
    cmd_word[32]    = ptt;
    cmd_word[31:0]  = data;
    cmd_strobe      = 1'b1;
    @(negedge clk_ad9866);
    cmd_strobe = 1'b0;
    apply_cmd(run, ptt, addr, data);
  endtask

  // Upper nibble with rxsync, then lower nibble
  task automatic send_sample(adc_sample_t s);
    // Sometimes a stray upper nibble that resync must discard
    if ($urandom_range(0, 7) == 0)
    begin
      @(negedge clk_ad9866);
      rffe_ad9866_rxsync = 1'b1;
      rffe_ad9866_rx     = nibble_t'($urandom);
    end
    @(negedge clk_ad9866);
    rffe_ad9866_rxsync = 1'b1;
    rffe_ad9866_rx     = s[11:6];
    @(negedge clk_ad9866);
    rffe_ad9866_rxsync = 1'b0;
    rffe_ad9866_rx     = s[5:0];
    model_sample(s);
  endtask

  // One pop, empty pops included
  task automatic pop_word();
    @(negedge clk_ad9866);
    if (m_fifo.size() > 0)
    begin
      check_iq("rx_data", rx_data, m_fifo[0]);
      m_fifo.delete(0);
    end
    rx_rd = 1'b1;
    @(negedge clk_ad9866);
    rx_rd = 1'b0;
    check_count("rx_count", rx_count, fifo_count_t'(m_fifo.size()));
    check_flag("rx_samples", rx_samples, m_fifo.size() >= `RADIO_BURST);
  endtask

  //------------------------------------------------------------------------
  // Waits, each bounded
  //------------------------------------------------------------------------
  task automatic wait_count();
    int n;
    n = 0;
    while (rx_count !== fifo_count_t'(m_fifo.size()) && n < WAIT_LIMIT)
    begin
      @(negedge clk_ad9866);
      n++;
    end
    if (rx_count !== fifo_count_t'(m_fifo.size()))
      report_timeout("rx_count to reach the model count");
    check_count("rx_count", rx_count, fifo_count_t'(m_fifo.size()));
    check_flag("rx_samples", rx_samples, m_fifo.size() >= `RADIO_BURST);
    check_flag("rxclip", rxclip, m_clip);
  endtask

  task automatic wait_clip();
    int n;
    n = 0;
    while (rxclip !== m_clip && n < WAIT_LIMIT)
    begin
      @(negedge clk_ad9866);
      n++;
    end
    if (rxclip !== m_clip)
      report_timeout("rxclip to change");
    check_flag("rxclip", rxclip, m_clip);
  endtask

  task automatic wait_txsync();
    int n;
    n = 0;
    while (rffe_ad9866_txsync !== 1'b1 && n < WAIT_LIMIT)
    begin
      @(negedge clk_ad9866);
      n++;
    end
    if (rffe_ad9866_txsync !== 1'b1)
      report_timeout("the first upper transmit nibble");
  endtask

  task automatic wait_quiet();
    int n;
    n = 0;
    while (rffe_ad9866_txquiet_n !== 1'b0 && n < WAIT_LIMIT)
    begin
      @(negedge clk_ad9866);
      n++;
    end
    if (rffe_ad9866_txquiet_n !== 1'b0)
      report_timeout("txquiet_n to go low");
    check_flag("rffe_ad9866_txquiet_n", rffe_ad9866_txquiet_n, 1'b0);
    check_nibble("rffe_ad9866_tx", rffe_ad9866_tx, '0);
    check_flag("rffe_ad9866_txsync", rffe_ad9866_txsync, 1'b0);
  endtask

  //------------------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------------------
  initial
  begin
    adc_sample_t e;
    int          nsmp;
    int          afails;
    void'($urandom(32'h98500eb7));
    reset              = 1'b1;
    cmd_strobe         = 1'b0;
    cmd_word           = '0;
    rffe_ad9866_rx     = '0;
    rffe_ad9866_rxsync = 1'b0;
    tx_sample          = '0;
    rx_rd              = 1'b0;
    m_run       = 1'b0;
    m_ptt       = 1'b0;
    m_decim     = '0;
    m_decim_act = '0;
    m_shift     = '0;
    m_acc       = '0;
    m_cnt       = 0;
    m_clip      = 1'b0;

    repeat (8) @(negedge clk_ad9866);
    check_flag("rffe_ad9866_rst_n", rffe_ad9866_rst_n, 1'b0);
    reset = 1'b0;
    @(negedge clk_ad9866);
    check_flag("rffe_ad9866_rst_n", rffe_ad9866_rst_n, 1'b1);
    check_count("rx_count", rx_count, '0);
    check_flag("rx_samples", rx_samples, 1'b0);
    check_flag("rxclip", rxclip, 1'b0);
    check_flag("rffe_ad9866_txsync", rffe_ad9866_txsync, 1'b0);
    check_flag("rffe_ad9866_txquiet_n", rffe_ad9866_txquiet_n, 1'b0);

    // Decimated sums in order, ratio sometimes changed mid-run
    for (int b = 0; b < 8; b++)
    begin
      send_cmd(1'b0, 1'b0, `RADIO_ADDR_DECIM, $urandom);
      send_cmd(1'b1, 1'b0, ADDR_NONE, $urandom);
      nsmp = $urandom_range(1, 40);
      for (int i = 0; i < nsmp; i++)
      begin
        if (i == nsmp / 2 && $urandom_range(0, 1) == 1)
          send_cmd(1'b1, 1'b0, `RADIO_ADDR_DECIM, $urandom);
        send_sample(adc_sample_t'($urandom));
      end
      send_cmd(1'b0, 1'b0, ADDR_NONE, $urandom);
      wait_count();
      while (m_fifo.size() > 0)
        pop_word();
    end

    // Stopped receive path writes nothing
    repeat (10) send_sample(adc_sample_t'($urandom));
    repeat (8) @(negedge clk_ad9866);
    check_count("rx_count", rx_count, fifo_count_t'(m_fifo.size()));

    // Overflow keeps the oldest 64, then empty pops
    send_cmd(1'b0, 1'b0, `RADIO_ADDR_DECIM, 32'd0);
    send_cmd(1'b1, 1'b0, ADDR_NONE, $urandom);
    repeat (70) send_sample(adc_sample_t'($urandom));
    send_cmd(1'b0, 1'b0, ADDR_NONE, $urandom);
    wait_count();
    while (m_fifo.size() > 0)
      pop_word();
    repeat (3) pop_word();

    // Full-scale codes set rxclip, clear-status drops it
    send_cmd(1'b0, 1'b0, `RADIO_ADDR_CLRSTAT, $urandom);
    wait_clip();
    for (int k = 0; k < 2; k++)
    begin
      send_sample((k == 0) ? 12'sh7FF : 12'sh800);
      wait_clip();
      send_cmd(1'b0, 1'b0, `RADIO_ADDR_CLRSTAT, $urandom);
      wait_clip();
    end

    // Transmit split with random gain, then quiet
    for (int r = 0; r < 4; r++)
    begin
      tx_sample = adc_sample_t'($urandom);
      send_cmd(1'b0, 1'b0, `RADIO_ADDR_GAIN, $urandom);
      send_cmd(1'b0, 1'b1, ADDR_NONE, $urandom);
      wait_txsync();
      for (int k = 0; k < 4; k++)
      begin
        e = tx_sample >>> m_shift;
        check_flag("rffe_ad9866_txsync", rffe_ad9866_txsync, 1'b1);
        check_flag("rffe_ad9866_txquiet_n", rffe_ad9866_txquiet_n, 1'b1);
        check_nibble("rffe_ad9866_tx", rffe_ad9866_tx, e[11:6]);
        @(negedge clk_ad9866);
        check_flag("rffe_ad9866_txsync", rffe_ad9866_txsync, 1'b0);
        check_nibble("rffe_ad9866_tx", rffe_ad9866_tx, e[5:0]);
        // New sample lands on the next upper nibble
        tx_sample = adc_sample_t'($urandom);
        @(negedge clk_ad9866);
      end
      send_cmd(1'b0, 1'b0, ADDR_NONE, $urandom);
      wait_quiet();
    end

    afails = int'(radio_core_i.radio_core_asserts_i.fail_count);
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, afails);
    if (mismatches + timeouts + afails == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
radio_pkg.sv
radio_cfg_if.sv
cmd_regs.sv
ad9866_port.sv
rx_decimator.sv
usiq_fifo.sv
radio_core.sv
tb_clock.sv
radio_core_asserts.sv
radio_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the radio core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module radio_core_tb -f filelist.f -o radio_core_sim

status=0
./obj_dir/radio_core_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
  echo "run_sim: FAILED"
  exit 1
fi
echo "run_sim: passed"
exit 0
